//--- hdl/emmu_pkg.sv
// shared geometry of the eMesh packet and translation table, referenced by scoped name
package emmu_pkg;

  // packet format
  localparam int pw = 104;      // full eMesh packet
  localparam int addr_lo = 8;   // dstaddr sits at packet bits 39:8

  // mi register interface
  localparam int dw = 32;       // mi data width, also the low half of an entry

  // translation table
  localparam int tab_aw = 12;   // 4096 entries
  localparam int tab_dw = 48;   // only bits 43:0 feed the translated address

  // untouched page offset
  localparam int off_w = 20;

  // destination address as seen by the translator
  // raw for passthrough, page for table lookup
  typedef union packed {
    logic [dw-1:0] raw;          // whole dstaddr
    struct packed {
      logic [tab_aw-1:0] index;  // dstaddr[31:20], table select
      logic [off_w-1:0] offset;  // dstaddr[19:0], carried through
    } page;
  } emesh_addr_u;

  // index plus offset must fill the address word exactly
  // 12 + 20 = 32, so the union has no padding

  // entry layout, for reference
  //   [31:0]  low half, written by mi_addr[2] = 0
  //   [47:32] high half, written by mi_addr[2] = 1
  //   [43:0]  upper 44 bits of the translated 64 bit address
  //   [47:44] spare, stored and read back only

  // translated address layout
  //   [63:20] entry[43:0]
  //   [19:0]  page offset
  //   [31:0]  goes back into the packet
  //   [63:32] leaves on the hi port

  // mi address layout
  //   [14:3] entry select
  //   [2]    half select
  //   [1:0]  word aligned, ignored
  //   [15]   ignored

endpackage

//--- hdl/emmu_table_ram.sv
// single-port 4096x48 translation table, registered read, independent half writes
`timescale 1ns/1ps

module emmu_table_ram (
  input  logic                          clk,
  input  logic                          ram_en,     // read or write this cycle
  input  logic                          ram_we_lo,  // write bits 31:0
  input  logic                          ram_we_hi,  // write bits 47:32
  input  logic [emmu_pkg::tab_aw-1:0]   ram_addr,
  input  logic [emmu_pkg::tab_dw-1:0]   ram_wdata,
  output logic [emmu_pkg::tab_dw-1:0]   ram_rdata   // valid one cycle after ram_en
);

  // table storage, contents undefined until written
  logic [emmu_pkg::tab_dw-1:0] mem [2**emmu_pkg::tab_aw];

  // read-first: a write returns the old entry
  always_ff @(posedge clk) begin
    if (ram_en) begin
      ram_rdata <= mem[ram_addr];
    end
  end

  // low half write
  always_ff @(posedge clk) begin
    if (ram_en && ram_we_lo) begin
      mem[ram_addr][emmu_pkg::dw-1:0] <= ram_wdata[emmu_pkg::dw-1:0];
    end
  end

  // high half write, low half untouched
  always_ff @(posedge clk) begin
    if (ram_en && ram_we_hi) begin
      mem[ram_addr][emmu_pkg::tab_dw-1:emmu_pkg::dw] <=
        ram_wdata[emmu_pkg::tab_dw-1:emmu_pkg::dw];
    end
  end

  // rdata holds between accesses
  // so an idle table keeps the last entry on the output

endmodule

//--- hdl/emmu_arbiter.sv
// fixed-priority owner of the table port, translator first, config port on free cycles
`timescale 1ns/1ps

module emmu_arbiter (
  input  logic                          clk,
  input  logic                          rst_n,
  // translator side, never stalls
  input  logic                          xl_req,
  input  logic [emmu_pkg::tab_aw-1:0]   xl_idx,
  // config side, waits for a gap
  input  logic                          cfg_req,    // level until cfg_done
  input  logic                          cfg_we,
  input  logic                          cfg_half,   // 0 low word, 1 high 16 bits
  input  logic [emmu_pkg::tab_aw-1:0]   cfg_idx,
  input  logic [emmu_pkg::dw-1:0]       cfg_wdata,
  output logic                          cfg_done,   // op performed this cycle
  output logic                          cfg_rvalid, // read data on ram_rdata now
  // table port
  output logic                          ram_en,
  output logic                          ram_we_lo,
  output logic                          ram_we_hi,
  output logic [emmu_pkg::tab_aw-1:0]   ram_addr,
  output logic [emmu_pkg::tab_dw-1:0]   ram_wdata,
  input  logic [emmu_pkg::tab_dw-1:0]   ram_rdata
);

  logic xl_gnt;     // translator owns the port
  logic cfg_gnt;    // config port owns the port
  logic cfg_rd_q;   // last read was issued for the config port

  // translator wins every cycle it asks
  assign xl_gnt  = xl_req;
  assign cfg_gnt = cfg_req & ~xl_req;

  assign ram_en   = xl_gnt | cfg_gnt;
  assign ram_addr = xl_gnt ? xl_idx : cfg_idx;

  // writes only ever come from the config side
  assign ram_we_lo = cfg_gnt & cfg_we & ~cfg_half;
  assign ram_we_hi = cfg_gnt & cfg_we & cfg_half;

  // place write data in the addressed half, other half zero
  always_comb begin
    ram_wdata = '0;
    if (cfg_half) begin
      ram_wdata[emmu_pkg::tab_dw-1:emmu_pkg::dw] =
        cfg_wdata[emmu_pkg::tab_dw-emmu_pkg::dw-1:0];  // only 16 bits fit
    end else begin
      ram_wdata[emmu_pkg::dw-1:0] = cfg_wdata;
    end
  end

  assign cfg_done = cfg_gnt;  // one pulse, pending op clears on it

  // remember who issued the read now in flight
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_rd_q <= 1'b0;
    end else begin
      cfg_rd_q <= cfg_gnt & ~cfg_we;
    end
  end

  // ram_rdata is shared, this flags the config copy
  assign cfg_rvalid = cfg_rd_q;

  // translator reads ram_rdata directly one cycle after xl_req
  // no valid needed there since it never loses arbitration

endmodule

//--- hdl/emmu_cfg_port.sv
// mi register access front end, holds one table operation and returns readback
`timescale 1ns/1ps

module emmu_cfg_port (
  input  logic                          clk,
  input  logic                          rst_n,
  // mi interface
  input  logic                          mi_en,      // sampled on the edge
  input  logic                          mi_we,
  input  logic [15:0]                   mi_addr,
  input  logic [emmu_pkg::dw-1:0]       mi_din,
  output logic [emmu_pkg::dw-1:0]       mi_dout,
  output logic                          mi_dout_valid,
  output logic                          mi_busy,
  // request to the arbiter
  output logic                          cfg_req,
  output logic                          cfg_we,
  output logic                          cfg_half,
  output logic [emmu_pkg::tab_aw-1:0]   cfg_idx,
  output logic [emmu_pkg::dw-1:0]       cfg_wdata,
  input  logic                          cfg_done,
  input  logic                          cfg_rvalid,
  input  logic [emmu_pkg::tab_dw-1:0]   ram_rdata
);

  logic                        pend_q;   // operation waiting for the table
  logic                        we_q;
  logic                        half_q;   // mi_addr[2]
  logic [emmu_pkg::tab_aw-1:0] idx_q;    // mi_addr[14:3]
  logic [emmu_pkg::dw-1:0]     wdata_q;
  logic [emmu_pkg::dw-1:0]     rd_sel;   // addressed half of the entry
  logic [emmu_pkg::dw-1:0]     dout_q;   // last readback, held
  logic                        accept;

  // new access only when idle, mi_en during busy is dropped
  assign accept = mi_en & ~pend_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= 1'b0;
    end else if (accept) begin
      pend_q <= 1'b1;
    end else if (cfg_done) begin
      pend_q <= 1'b0;  // table did it this cycle
    end
  end

  // operation payload, only loaded on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      we_q    <= mi_we;
      half_q  <= mi_addr[2];
      idx_q   <= mi_addr[14:3];
      wdata_q <= mi_din;
    end
  end

  assign cfg_req   = pend_q;
  assign cfg_we    = we_q;
  assign cfg_half  = half_q;
  assign cfg_idx   = idx_q;
  assign cfg_wdata = wdata_q;

  // busy from the cycle after mi_en until the op is done
  assign mi_busy = pend_q;

  // high half comes back zero-extended
  assign rd_sel = half_q ?
    {{(2*emmu_pkg::dw-emmu_pkg::tab_dw){1'b0}},
     ram_rdata[emmu_pkg::tab_dw-1:emmu_pkg::dw]} :
    ram_rdata[emmu_pkg::dw-1:0];

  // keep the value after the pulse, ram_rdata moves on with traffic
  always_ff @(posedge clk) begin
    if (cfg_rvalid) begin
      dout_q <= rd_sel;
    end
  end

  assign mi_dout       = cfg_rvalid ? rd_sel : dout_q;
  assign mi_dout_valid = cfg_rvalid;  // one cycle after cfg_done of a read

endmodule

//--- hdl/emmu_xlate.sv
// eMesh packet path, issues the table lookup and rebuilds the packet with the translated address
`timescale 1ns/1ps

module emmu_xlate (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          mmu_en,        // 0 passes the address through
  // eMesh in
  input  logic                          emesh_access_in,
  input  logic [emmu_pkg::pw-1:0]       emesh_packet_in,
  // lookup
  output logic                          xl_req,
  output logic [emmu_pkg::tab_aw-1:0]   xl_idx,
  input  logic [emmu_pkg::tab_dw-1:0]   ram_rdata,     // entry, one cycle after xl_req
  // eMesh out
  output logic                          emmu_access_out,
  output logic [emmu_pkg::pw-1:0]       emmu_packet_out,
  output logic [emmu_pkg::dw-1:0]       emmu_packet_hi_out
);

  localparam int ent_w = 2*emmu_pkg::dw - emmu_pkg::off_w;  // 44 entry bits used
  localparam int da_hi = emmu_pkg::addr_lo + emmu_pkg::dw;  // first bit above dstaddr

  emmu_pkg::emesh_addr_u in_addr;   // incoming dstaddr
  emmu_pkg::emesh_addr_u pkt_addr;  // dstaddr of the packet in flight

  logic                          access_q;
  logic [emmu_pkg::pw-1:0]       pkt_q;     // packet waiting for its entry
  logic [ent_w-1:0]              ent_q;     // entry of the last translated packet
  logic [ent_w-1:0]              entry;
  logic [2*emmu_pkg::dw-1:0]     xaddr;     // full 64 bit output address

  // lookup goes out the same cycle as the access
  assign in_addr.raw = emesh_packet_in[da_hi-1:emmu_pkg::addr_lo];
  assign xl_req      = emesh_access_in;
  assign xl_idx      = in_addr.page.index;

  // strobe delay matches the registered table read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      access_q <= 1'b0;
    end else begin
      access_q <= emesh_access_in;
    end
  end

  // one packet in flight, replaced on every access
  always_ff @(posedge clk) begin
    if (emesh_access_in) begin
      pkt_q <= emesh_packet_in;
    end
  end

  // ram_rdata may change under config reads while idle
  // so hold the entry that belongs to pkt_q
  always_ff @(posedge clk) begin
    if (access_q) begin
      ent_q <= ram_rdata[ent_w-1:0];
    end
  end

  assign entry    = access_q ? ram_rdata[ent_w-1:0] : ent_q;
  assign pkt_addr.raw = pkt_q[da_hi-1:emmu_pkg::addr_lo];

  // translated {entry, offset}, or raw address with zero upper word
  assign xaddr = mmu_en ? {entry, pkt_addr.page.offset} :
                          {{emmu_pkg::dw{1'b0}}, pkt_addr.raw};

  // splice low word back, rest of the packet untouched
  assign emmu_packet_out = {pkt_q[emmu_pkg::pw-1:da_hi],
                            xaddr[emmu_pkg::dw-1:0],
                            pkt_q[emmu_pkg::addr_lo-1:0]};  // ctrl byte

  assign emmu_packet_hi_out = xaddr[2*emmu_pkg::dw-1:emmu_pkg::dw];
  assign emmu_access_out    = access_q;

endmodule

//--- hdl/emmu_top.sv
// eMesh MMU subsystem, translator and mi config port sharing one table through an arbiter
`timescale 1ns/1ps

module emmu_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      mmu_en,
  // mi register access
  input  logic                      mi_en,
  input  logic                      mi_we,
  input  logic [15:0]               mi_addr,
  input  logic [emmu_pkg::dw-1:0]   mi_din,
  output logic [emmu_pkg::dw-1:0]   mi_dout,
  output logic                      mi_dout_valid,
  output logic                      mi_busy,
  // eMesh
  input  logic                      emesh_access_in,
  input  logic [emmu_pkg::pw-1:0]   emesh_packet_in,
  output logic                      emmu_access_out,
  output logic [emmu_pkg::pw-1:0]   emmu_packet_out,
  output logic [emmu_pkg::dw-1:0]   emmu_packet_hi_out
);

  // translator to arbiter
  logic                        xl_req;
  logic [emmu_pkg::tab_aw-1:0] xl_idx;

  // config port to arbiter
  logic                        cfg_req;
  logic                        cfg_we;
  logic                        cfg_half;
  logic [emmu_pkg::tab_aw-1:0] cfg_idx;
  logic [emmu_pkg::dw-1:0]     cfg_wdata;
  logic                        cfg_done;
  logic                        cfg_rvalid;

  // arbiter to table
  logic                        ram_en;
  logic                        ram_we_lo;
  logic                        ram_we_hi;
  logic [emmu_pkg::tab_aw-1:0] ram_addr;
  logic [emmu_pkg::tab_dw-1:0] ram_wdata;
  logic [emmu_pkg::tab_dw-1:0] ram_rdata;  // shared by both peers

  emmu_xlate u_xlate (
    .clk, .rst_n, .mmu_en,
    .emesh_access_in, .emesh_packet_in,
    .xl_req, .xl_idx, .ram_rdata,
    .emmu_access_out, .emmu_packet_out, .emmu_packet_hi_out
  );

  emmu_cfg_port u_cfg (
    .clk, .rst_n,
    .mi_en, .mi_we, .mi_addr, .mi_din,
    .mi_dout, .mi_dout_valid, .mi_busy,
    .cfg_req, .cfg_we, .cfg_half, .cfg_idx, .cfg_wdata,
    .cfg_done, .cfg_rvalid, .ram_rdata
  );

  emmu_arbiter u_arb (
    .clk, .rst_n,
    .xl_req, .xl_idx,
    .cfg_req, .cfg_we, .cfg_half, .cfg_idx, .cfg_wdata,
    .cfg_done, .cfg_rvalid,
    .ram_en, .ram_we_lo, .ram_we_hi, .ram_addr, .ram_wdata, .ram_rdata
  );

  emmu_table_ram u_ram (
    .clk, .ram_en, .ram_we_lo, .ram_we_hi, .ram_addr, .ram_wdata, .ram_rdata
  );

endmodule

//--- sim/emmu_chk.sv
// concurrent checks on arbitration and the mi protocol, bound into the arbiter and the top level
`timescale 1ns/1ps

module emmu_chk (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        xl_req,
  input logic [emmu_pkg::tab_aw-1:0] xl_idx,
  input logic                        cfg_done,
  input logic                        ram_en,
  input logic                        ram_we_lo,
  input logic                        ram_we_hi,
  input logic [emmu_pkg::tab_aw-1:0] ram_addr,
  input logic                        mi_en,           // tied low where not visible
  input logic                        mi_busy,
  input logic                        emesh_access_in,
  input logic                        emmu_access_out
);

  // single-port table, a lookup cycle carries the translator index and no write
  a_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
    xl_req |-> ram_en && ram_addr == xl_idx && !ram_we_lo && !ram_we_hi)
    else $error("config port took the table during a translator lookup");

  // config op only lands in a translator gap
  a_done_gap: assert property (@(posedge clk) disable iff (!rst_n) !(cfg_done && xl_req))
    else $error("cfg_done while xl_req high");

  a_mi_idle: assert property (@(posedge clk) disable iff (!rst_n) !(mi_en && mi_busy))
    else $error("mi_en asserted while mi_busy high");

  // fixed one cycle latency on the eMesh side
  a_access_lat: assert property (@(posedge clk) disable iff (!rst_n)
    emmu_access_out == $past(emesh_access_in))
    else $error("emmu_access_out does not follow emesh_access_in by one cycle");

endmodule

bind emmu_arbiter emmu_chk u_arb_chk (
  .clk, .rst_n, .xl_req, .xl_idx, .cfg_done,
  .ram_en, .ram_we_lo, .ram_we_hi, .ram_addr,
  .mi_en(1'b0), .mi_busy(1'b0), .emesh_access_in(1'b0), .emmu_access_out(1'b0)
);

bind emmu_top emmu_chk u_top_chk (
  .clk, .rst_n, .xl_req, .xl_idx, .cfg_done,
  .ram_en, .ram_we_lo, .ram_we_hi, .ram_addr,
  .mi_en, .mi_busy, .emesh_access_in, .emmu_access_out
);

//--- sim/emmu_tb.sv
// directed testbench for the eMesh MMU, drives mi and eMesh traffic against a table model
`timescale 1ns/1ps

module emmu_tb;

  localparam int half_period = 20;               // 40 ns clock
  localparam int n_ent = 8;                      // entries programmed by table_rw
  localparam int op_limit = 300;                 // cycles before an mi access counts as stuck
  // cycles per test: reset, table_rw, translate, passthrough, back_to_back, cfg_under_traffic
  localparam int budget = 10 + n_ent * 40 + 40 + 40 + 220 + 120;

  logic                          clk;
  logic                          rst_n;
  logic                          mmu_en;
  logic                          mi_en;
  logic                          mi_we;
  logic [15:0]                   mi_addr;
  logic [emmu_pkg::dw-1:0]       mi_din;
  logic [emmu_pkg::dw-1:0]       mi_dout;
  logic                          mi_dout_valid;
  logic                          mi_busy;
  logic                          emesh_access_in;
  logic [emmu_pkg::pw-1:0]       emesh_packet_in;
  logic                          emmu_access_out;
  logic [emmu_pkg::pw-1:0]       emmu_packet_out;
  logic [emmu_pkg::dw-1:0]       emmu_packet_hi_out;

  logic [emmu_pkg::tab_dw-1:0]   model [int];    // reference table, written entries only
  int                            prog[$];        // indices with both halves written
  logic [emmu_pkg::pw-1:0]       exp_pkt[$];     // expected outputs in order
  logic [emmu_pkg::dw-1:0]       exp_hi[$];
  string                         cur_test;
  int                            errors;
  int                            checks;

  emmu_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  initial begin
    #(budget * 2 * half_period + 4000);
    $display("watchdog expired, tests did not finish in time");
    $display("Something failed");
    $finish;
  end

  task automatic compare_value(input string what, input logic [103:0] exp,
                               input logic [103:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s %s expected %0h actual %0h", cur_test, what, exp, act);
    end
  endtask

  // output monitor, sampled mid-cycle
  initial begin
    logic prev_acc;
    prev_acc = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n) begin
        compare_value("access_out", 104'(prev_acc), 104'(emmu_access_out));
        if (emmu_access_out === 1'b1 && exp_pkt.size() == 0) begin
          errors++;
          $display("%s: packet came out with none outstanding", cur_test);
        end else if (emmu_access_out === 1'b1) begin
          compare_value("packet", exp_pkt.pop_front(), emmu_packet_out);
          compare_value("hi word", 104'(exp_hi.pop_front()), 104'(emmu_packet_hi_out));
        end
      end
      prev_acc = emesh_access_in;  // driven on the last posedge
    end
  end

  // one mi access, returns once the table has done it
  task automatic mi_op(input logic we, input logic [11:0] idx, input logic half,
                       input logic [31:0] din, output logic [31:0] dout);
    int  n;
    logic done;
    n = 0;
    done = 1'b0;
    @(posedge clk);
    mi_en   <= 1'b1;
    mi_we   <= we;
    mi_addr <= {1'b0, idx, half, 2'b00};
    mi_din  <= din;
    @(posedge clk);
    mi_en <= 1'b0;  // busy is up from here
    while (!done && n < op_limit) begin
      @(negedge clk);
      n++;
      done = we ? !mi_busy : mi_dout_valid;  // reads end on the valid pulse
    end
    if (!done) begin
      errors++;
      $display("%s: mi access to entry %0h never completed", cur_test, idx);
    end
    dout = mi_dout;
  endtask

  task automatic write_half(input logic [11:0] idx, input logic half, input logic [31:0] din);
    logic [31:0] unused;
    logic [47:0] ent;
    mi_op(1'b1, idx, half, din, unused);
    ent = model.exists(int'(idx)) ? model[int'(idx)] : 'x;
    if (half) ent[47:32] = din[15:0];  // only 16 bits stored
    else ent[31:0] = din;
    model[int'(idx)] = ent;
  endtask

  task automatic read_check(input logic [11:0] idx, input logic half);
    logic [31:0] got;
    logic [47:0] ent;
    mi_op(1'b0, idx, half, '0, got);
    ent = model[int'(idx)];
    compare_value(half ? "readback hi" : "readback lo",
                  104'(half ? {16'h0, ent[47:32]} : ent[31:0]), 104'(got));
  endtask

  // one access to entry idx, expected result queued from the model
  task automatic send_packet(input logic [11:0] idx);
    logic [103:0] pkt;
    logic [47:0]  ent;
    logic [63:0]  xa;
    pkt[31:0]   = $urandom();
    pkt[63:32]  = $urandom();
    pkt[95:64]  = $urandom();
    pkt[103:96] = 8'($urandom());
    pkt[39:28]  = idx;               // dstaddr[31:20]
    if (mmu_en) begin
      ent = model[int'(idx)];
      xa = {ent[43:0], pkt[27:8]};   // entry then page offset
      exp_pkt.push_back({pkt[103:40], xa[31:0], pkt[7:0]});
      exp_hi.push_back(xa[63:32]);
    end else begin
      exp_pkt.push_back(pkt);
      exp_hi.push_back('0);
    end
    @(posedge clk);
    emesh_access_in <= 1'b1;
    emesh_packet_in <= pkt;
  endtask

  task automatic drain();
    @(posedge clk);
    emesh_access_in <= 1'b0;
    repeat (3) @(negedge clk);
    if (exp_pkt.size() != 0) begin
      errors++;
      $display("%s: %0d expected packets never came out", cur_test, exp_pkt.size());
      exp_pkt.delete();
      exp_hi.delete();
    end
  endtask

  task automatic test_table_rw();
    logic [11:0] idx;
    cur_test = "table_rw";
    for (int i = 0; i < n_ent; i++) begin
      do idx = 12'($urandom()); while (model.exists(int'(idx)));
      write_half(idx, 1'b0, $urandom());
      write_half(idx, 1'b1, $urandom());
      prog.push_back(int'(idx));
      read_check(idx, 1'b0);
      read_check(idx, 1'b1);
    end
    // rewrite one half, the other has to survive
    foreach (prog[i]) begin
      write_half(12'(prog[i]), 1'(i), $urandom());
      read_check(12'(prog[i]), 1'b0);
      read_check(12'(prog[i]), 1'b1);
    end
  endtask

  task automatic test_translate();
    cur_test = "translate";
    foreach (prog[i]) begin
      send_packet(12'(prog[i]));
      @(posedge clk);
      emesh_access_in <= 1'b0;  // idle gap
    end
    drain();
  endtask

  task automatic test_passthrough();
    cur_test = "passthrough";
    @(posedge clk);
    mmu_en <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < 16; i++) send_packet(12'($urandom()));
    drain();
    @(posedge clk);
    mmu_en <= 1'b1;
    @(negedge clk);
  endtask

  task automatic test_back_to_back();
    cur_test = "back_to_back";
    for (int i = 0; i < 200; i++) send_packet(12'(prog[$urandom_range(prog.size() - 1)]));
    drain();
  endtask

  task automatic test_cfg_under_traffic();
    logic [11:0] idx;
    logic [47:0] old_ent;
    cur_test = "cfg_under_traffic";
    idx = 12'(prog[0]);
    old_ent = model[int'(idx)];
    fork
      begin
        for (int i = 0; i < 40; i++) begin
          send_packet(idx);  // old entry expected throughout
          @(negedge clk);
          if (i >= 8 && mi_busy !== 1'b1) begin
            errors++;
            $display("%s: mi_busy low during traffic at packet %0d", cur_test, i);
          end
        end
        @(posedge clk);
        emesh_access_in <= 1'b0;  // first free cycle for the write
      end
      begin
        repeat (4) @(posedge clk);
        write_half(idx, 1'b0, ~old_ent[31:0]);
      end
    join
    send_packet(idx);  // sees the new low word
    drain();
  endtask

  initial begin
    void'($urandom(88280));
    errors          = 0;
    checks          = 0;
    cur_test        = "reset";
    rst_n           = 1'b0;
    mmu_en          = 1'b1;
    mi_en           = 1'b0;
    mi_we           = 1'b0;
    mi_addr         = '0;
    mi_din          = '0;
    emesh_access_in = 1'b0;
    emesh_packet_in = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (emmu_access_out !== 1'b0 || mi_busy !== 1'b0 || mi_dout_valid !== 1'b0) begin
      errors++;
      $display("outputs not idle after reset");
    end
    test_table_rw();
    test_translate();
    test_passthrough();
    test_back_to_back();
    test_cfg_under_traffic();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- src.f
hdl/emmu_pkg.sv
hdl/emmu_table_ram.sv
hdl/emmu_arbiter.sv
hdl/emmu_cfg_port.sv
hdl/emmu_xlate.sv
hdl/emmu_top.sv
sim/emmu_chk.sv
sim/emmu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile the testbench with Verilator, run it, and judge the run from its log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module emmu_tb -f src.f -o emmu_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/emmu_sim > sim.log 2>&1
cat sim.log

grep -q "Something failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Everything OK" sim.log && { echo "simulation passed"; exit 0; } \
  || { echo "simulation ended early"; exit 1; }
